/* blocking_cache.sv */
//============================================================
// Blocking two-way cache top level
//============================================================

`timescale 1ns/1ps

module blocking_cache import cache_pkg::*; (
  input  logic                        clk,
  input  logic                        reset,

  input  logic                        cachereq_val,
  output logic                        cachereq_rdy,
  input  cache_req_t                  cachereq_msg,

  output logic                        cacheresp_val,
  input  logic                        cacheresp_rdy,
  output cache_resp_t                 cacheresp_msg,

  output logic                        memreq_val,
  input  logic                        memreq_rdy,
  output mem_req_t                    memreq_msg,

  input  logic                        memresp_val,
  output logic                        memresp_rdy,
  input  mem_resp_t                   memresp_msg
);

  dpath_ctrl_t    ctrl;
  dpath_status_t  status;

  // Controller owns every valid and ready
  cache_ctrl cache_ctrl_inst (
    .clk            (clk),
    .reset          (reset),
    .status         (status),
    .cachereq_val   (cachereq_val),
    .cachereq_rdy   (cachereq_rdy),
    .cacheresp_val  (cacheresp_val),
    .cacheresp_rdy  (cacheresp_rdy),
    .memreq_val     (memreq_val),
    .memreq_rdy     (memreq_rdy),
    .memresp_val    (memresp_val),
    .memresp_rdy    (memresp_rdy),
    .ctrl           (ctrl)
  );

  cache_datapath cache_datapath_inst (
    .clk            (clk),
    .reset          (reset),
    .ctrl           (ctrl),
    .cachereq_msg   (cachereq_msg),
    .memresp_msg    (memresp_msg),
    .status         (status),
    .cacheresp_msg  (cacheresp_msg),
    .memreq_msg     (memreq_msg)
  );

endmodule

/* cache_ctrl.sv */
//============================================================
// Cache controller FSM with per-set valid, dirty and LRU bits
//============================================================

`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
  input  logic                        clk,
  input  logic                        reset,
  input  dpath_status_t               status,
  input  logic                        cachereq_val,
  output logic                        cachereq_rdy,
  output logic                        cacheresp_val,
  input  logic                        cacheresp_rdy,
  output logic                        memreq_val,
  input  logic                        memreq_rdy,
  input  logic                        memresp_val,
  output logic                        memresp_rdy,
  output dpath_ctrl_t                 ctrl
);

  typedef enum logic [3:0] {
    st_idle,
    st_tag_check,
    st_access,
    st_respond,
    st_evict_prepare,
    st_evict_request,
    st_evict_wait,
    st_refill_request,
    st_refill_wait,
    st_refill_update
  } state_t;

  state_t                               state;
  state_t                               next_state;

  logic [num_ways-1:0][num_sets-1:0]    valid_bits;
  logic [num_ways-1:0][num_sets-1:0]    dirty_bits;
  // Most recently used way per set
  logic [num_sets-1:0]                  mru_bits;

  index_t                               idx;
  logic [num_ways-1:0]                  hit_vec;
  logic                                 hit;
  logic                                 victim;
  logic                                 victim_dirty;
  logic                                 way_reg;

  assign idx = status.index;

  // A hit needs a matching tag in a valid way
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      hit_vec[w] = status.tag_match[w] & valid_bits[w][idx];
    end
  end

  assign hit          = |hit_vec;
  assign victim       = ~mru_bits[idx];
  assign victim_dirty = valid_bits[victim][idx] & dirty_bits[victim][idx];

  //==========================================================
  // State register and way chosen at tag check
  //==========================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= st_idle;
      way_reg <= 1'b0;
    end else begin
      state <= next_state;
      if (state == st_tag_check) begin
        way_reg <= hit ? hit_vec[1] : victim;
      end
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      st_idle:           if (cachereq_val) next_state = st_tag_check;
      st_tag_check: begin
        if (hit) begin
          next_state = st_access;
        end else if (victim_dirty) begin
          next_state = st_evict_prepare;
        end else begin
          next_state = st_refill_request;
        end
      end
      st_evict_prepare:  next_state = st_evict_request;
      st_evict_request:  if (memreq_rdy) next_state = st_evict_wait;
      st_evict_wait:     if (memresp_val) next_state = st_refill_request;
      st_refill_request: if (memreq_rdy) next_state = st_refill_wait;
      st_refill_wait:    if (memresp_val) next_state = st_refill_update;
      st_refill_update:  next_state = st_access;
      st_access:         next_state = st_respond;
      st_respond:        if (cacheresp_rdy) next_state = st_idle;
      default:           next_state = st_idle;
    endcase
  end

  //==========================================================
  // Outputs
  //==========================================================
  always_comb begin
    cachereq_rdy  = 1'b0;
    cacheresp_val = 1'b0;
    memreq_val    = 1'b0;
    memresp_rdy   = 1'b0;
    ctrl          = '0;
    ctrl.way      = way_reg;
    ctrl.mem_op   = cache_read;
    case (state)
      st_idle: begin
        cachereq_rdy = 1'b1;
        ctrl.req_en  = cachereq_val;
      end
      st_evict_prepare: ctrl.evict_reg_en = 1'b1;
      st_evict_request: begin
        memreq_val          = 1'b1;
        ctrl.mem_addr_evict = 1'b1;
        ctrl.mem_op         = cache_write;
      end
      // Write acknowledge carries nothing we keep
      st_evict_wait:     memresp_rdy = 1'b1;
      st_refill_request: memreq_val  = 1'b1;
      // Response is already valid here, take it and write the line
      st_refill_update: begin
        memresp_rdy           = 1'b1;
        ctrl.tag_wen[way_reg] = 1'b1;
        ctrl.data_wen         = 1'b1;
        ctrl.line_write       = 1'b1;
      end
      st_access: begin
        ctrl.data_wen    = (status.op == cache_write);
        ctrl.read_reg_en = 1'b1;
      end
      st_respond: cacheresp_val = 1'b1;
      default: ;
    endcase
  end

  // Per-set state bits
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
      mru_bits   <= '0;
    end else if (state == st_refill_update) begin
      valid_bits[way_reg][idx] <= 1'b1;
      dirty_bits[way_reg][idx] <= 1'b0;
      mru_bits[idx]            <= way_reg;
    end else if (state == st_access) begin
      mru_bits[idx] <= way_reg;
      if (status.op == cache_write) begin
        dirty_bits[way_reg][idx] <= 1'b1;
      end
    end
  end

endmodule

/* cache_data_array.sv */
//============================================================
// Line store for both ways, word or full-line write
//============================================================

`timescale 1ns/1ps

module cache_data_array import cache_pkg::*; (
  input  logic                        clk,
  input  index_t                      index,
  input  logic                        way,
  input  logic                        wen,
  input  logic                        line_write,
  input  word_sel_t                   word_sel,
  input  logic [word_bits-1:0]        wdata_word,
  input  line_t                       wdata_line,
  output line_t                       rdata
);

  line_t                       lines [num_ways][num_sets];
  logic [words_per_line-1:0]   word_en;
  line_t                       wdata;

  // Word enables, all set for a refill
  always_comb begin
    word_en = '0;
    if (line_write) begin
      word_en = '1;
    end else begin
      word_en[word_sel] = 1'b1;
    end
  end

  // Merge the single word into every slot, enables pick the one
  always_comb begin
    for (int w = 0; w < words_per_line; w++) begin
      if (line_write) begin
        wdata[w*word_bits +: word_bits] = wdata_line[w*word_bits +: word_bits];
      end else begin
        wdata[w*word_bits +: word_bits] = wdata_word;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wen) begin
      for (int w = 0; w < words_per_line; w++) begin
        if (word_en[w]) begin
          lines[way][index][w*word_bits +: word_bits] <= wdata[w*word_bits +: word_bits];
        end
      end
    end
  end

  // Read is combinational from the selected way
  assign rdata = lines[way][index];

endmodule

/* cache_datapath.sv */
//============================================================
// Cache datapath: request register, tag and data arrays,
// read word and evict registers, memory request assembly
//============================================================

`timescale 1ns/1ps

module cache_datapath import cache_pkg::*; (
  input  logic                        clk,
  input  logic                        reset,
  input  dpath_ctrl_t                 ctrl,
  input  cache_req_t                  cachereq_msg,
  input  mem_resp_t                   memresp_msg,
  output dpath_status_t               status,
  output cache_resp_t                 cacheresp_msg,
  output mem_req_t                    memreq_msg
);

  cache_req_t             req;
  tag_t                   req_tag;
  index_t                 req_index;
  word_sel_t              req_word;

  tag_t [num_ways-1:0]    tags;
  logic [num_ways-1:0]    tag_match;
  line_t                  line_rdata;

  logic [word_bits-1:0]   read_word;
  line_t                  evict_line;
  tag_t                   evict_tag;
  tag_t                   mem_tag;

  //==========================================================
  // Request register and address split
  //==========================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      req <= '0;
    end else if (ctrl.req_en) begin
      req <= cachereq_msg;
    end
  end

  assign req_tag   = req.addr[offset_bits+index_bits +: tag_bits];
  assign req_index = req.addr[offset_bits +: index_bits];
  assign req_word  = req.addr[2 +: $bits(word_sel_t)];

  //==========================================================
  // Arrays
  //==========================================================
  cache_tag_array cache_tag_array_inst (
    .clk        (clk),
    .reset      (reset),
    .index      (req_index),
    .req_tag    (req_tag),
    .wen        (ctrl.tag_wen),
    .tags       (tags),
    .tag_match  (tag_match)
  );

  // Refill line straight from the memory response
  cache_data_array cache_data_array_inst (
    .clk        (clk),
    .index      (req_index),
    .way        (ctrl.way),
    .wen        (ctrl.data_wen),
    .line_write (ctrl.line_write),
    .word_sel   (req_word),
    .wdata_word (req.data),
    .wdata_line (memresp_msg.data),
    .rdata      (line_rdata)
  );

  //==========================================================
  // Response and victim registers
  //==========================================================
  // Held through back-pressure, loaded only during access
  always_ff @(posedge clk) begin
    if (ctrl.read_reg_en) begin
      if (req.op == cache_write) begin
        read_word <= '0;
      end else begin
        read_word <= line_rdata[req_word*word_bits +: word_bits];
      end
    end
  end

  // Victim line and its tag before the refill overwrites them
  always_ff @(posedge clk) begin
    if (ctrl.evict_reg_en) begin
      evict_line <= line_rdata;
      evict_tag  <= tags[ctrl.way];
    end
  end

  assign status.tag_match = tag_match;
  assign status.index     = req_index;
  assign status.op        = req.op;

  assign cacheresp_msg.op   = req.op;
  assign cacheresp_msg.data = read_word;

  // Line-aligned address, same index for victim and refill
  assign mem_tag         = ctrl.mem_addr_evict ? evict_tag : req_tag;
  assign memreq_msg.op   = ctrl.mem_op;
  assign memreq_msg.addr = {mem_tag, req_index, {offset_bits{1'b0}}};
  assign memreq_msg.data = (ctrl.mem_op == cache_write) ? evict_line : '0;

endmodule

/* cache_pkg.sv */
//============================================================
// Cache geometry, address field types, channel messages and
// the control and status structs between controller and datapath
//============================================================

package cache_pkg;

  //==========================================================
  // Geometry
  //==========================================================
  localparam int word_bits      = 32;
  localparam int line_bits      = 128;
  localparam int words_per_line = 4;
  localparam int num_sets       = 8;
  localparam int num_ways       = 2;
  localparam int offset_bits    = 4;
  localparam int index_bits     = 3;
  localparam int tag_bits       = 25;

  // Address fields
  typedef logic [tag_bits-1:0]                tag_t;
  typedef logic [index_bits-1:0]              index_t;
  typedef logic [$clog2(words_per_line)-1:0]  word_sel_t;
  typedef logic [line_bits-1:0]               line_t;

  typedef enum logic {
    cache_read  = 1'b0,
    cache_write = 1'b1
  } cache_op_t;

  //==========================================================
  // Channel messages
  //==========================================================
  typedef struct packed {
    cache_op_t              op;
    logic [31:0]            addr;
    logic [word_bits-1:0]   data;
  } cache_req_t;

  // Writes answer with zero data
  typedef struct packed {
    cache_op_t              op;
    logic [word_bits-1:0]   data;
  } cache_resp_t;

  typedef struct packed {
    cache_op_t              op;
    logic [31:0]            addr;
    line_t                  data;
  } mem_req_t;

  typedef struct packed {
    cache_op_t              op;
    line_t                  data;
  } mem_resp_t;

  //==========================================================
  // Controller and datapath
  //==========================================================
  typedef struct packed {
    logic [num_ways-1:0]    tag_match;
    index_t                 index;
    cache_op_t              op;
  } dpath_status_t;

  typedef struct packed {
    logic                   req_en;
    logic [num_ways-1:0]    tag_wen;
    logic                   data_wen;
    logic                   line_write;
    logic                   way;
    logic                   read_reg_en;
    logic                   evict_reg_en;
    logic                   mem_addr_evict;
    cache_op_t              mem_op;
  } dpath_ctrl_t;

endpackage

/* cache_props.sv */
//============================================================
// Handshake assertions for the cache top level and its bind
//============================================================

`timescale 1ns/1ps

module cache_props import cache_pkg::*; (
  input logic         clk,
  input logic         reset,
  input logic         cachereq_val,
  input logic         cachereq_rdy,
  input cache_req_t   cachereq_msg,
  input logic         cacheresp_val,
  input logic         cacheresp_rdy,
  input cache_resp_t  cacheresp_msg,
  input logic         memreq_val,
  input logic         memreq_rdy,
  input mem_req_t     memreq_msg,
  input logic         memresp_val,
  input logic         memresp_rdy,
  input mem_resp_t    memresp_msg
);

  // Each sender holds valid and payload until the transfer
  cachereq_hold: assert property (@(posedge clk) disable iff (reset)
    cachereq_val && !cachereq_rdy |=> cachereq_val && $stable(cachereq_msg))
    else $error("cachereq valid or payload changed before transfer");

  cacheresp_hold: assert property (@(posedge clk) disable iff (reset)
    cacheresp_val && !cacheresp_rdy |=> cacheresp_val && $stable(cacheresp_msg))
    else $error("cacheresp valid or payload changed under back-pressure");

  memreq_hold: assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val && $stable(memreq_msg))
    else $error("memreq valid or payload changed before transfer");

  memresp_hold: assert property (@(posedge clk) disable iff (reset)
    memresp_val && !memresp_rdy |=> memresp_val && $stable(memresp_msg))
    else $error("memresp valid or payload changed before transfer");

  // One request in flight at a time
  req_resp_excl: assert property (@(posedge clk) disable iff (reset)
    !(cachereq_rdy && cacheresp_val))
    else $error("cachereq_rdy and cacheresp_val high together");

  mem_excl: assert property (@(posedge clk) disable iff (reset)
    !(memreq_val && memresp_rdy))
    else $error("memreq_val and memresp_rdy high together");

endmodule

bind blocking_cache cache_props cache_props_inst (.*);

/* cache_tag_array.sv */
//============================================================
// Tag store for both ways, with a per-way compare against
// the tag of the held request
//============================================================

`timescale 1ns/1ps

module cache_tag_array import cache_pkg::*; (
  input  logic                        clk,
  input  logic                        reset,
  input  index_t                      index,
  input  tag_t                        req_tag,
  input  logic [num_ways-1:0]         wen,
  output tag_t [num_ways-1:0]         tags,
  output logic [num_ways-1:0]         tag_match
);

  tag_t [num_ways-1:0][num_sets-1:0] tag_mem;

  // One tag per way and set, written with the request tag on refill
  always_ff @(posedge clk) begin
    if (reset) begin
      tag_mem <= '0;
    end else begin
      for (int w = 0; w < num_ways; w++) begin
        if (wen[w]) begin
          tag_mem[w][index] <= req_tag;
        end
      end
    end
  end

  // Combinational read and compare, validity lives in the controller
  always_comb begin
    for (int w = 0; w < num_ways; w++) begin
      tags[w]      = tag_mem[w][index];
      tag_match[w] = (tag_mem[w][index] == req_tag);
    end
  end

endmodule

/* cache_tb.sv */
//============================================================
// Testbench for the blocking cache: line memory model,
// stimulus table with expected values, reference words
//============================================================

`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

  localparam int          reset_cycles = 10;
  localparam logic [31:0] fill_key     = 32'h5a5a_a5a5;

  typedef struct packed {
    cache_op_t    op;
    logic [31:0]  addr;
    logic [31:0]  wdata;
    logic [31:0]  exp_data;
    int           exp_rd;
    int           exp_wr;
    logic [31:0]  exp_wb;
    logic         no_stall;
  } test_t;

  logic         clk;
  logic         reset;
  logic         cachereq_val;
  logic         cachereq_rdy;
  cache_req_t   cachereq_msg;
  logic         cacheresp_val;
  logic         cacheresp_rdy;
  cache_resp_t  cacheresp_msg;
  logic         memreq_val;
  logic         memreq_rdy;
  mem_req_t     memreq_msg;
  logic         memresp_val;
  logic         memresp_rdy;
  mem_resp_t    memresp_msg;

  test_t        tests[$];
  string        names[$];
  string        cur_name;
  line_t        mem_lines [256];
  logic [31:0]  ref_words [1024];
  logic [31:0]  last_rd_addr;
  logic [31:0]  last_wb_addr;
  logic [31:0]  mem_lfsr  = 32'hda5a;
  logic [31:0]  resp_lfsr = 32'hda5a;
  int           mem_reads  = 0;
  int           mem_writes = 0;
  int           errors     = 0;

  blocking_cache blocking_cache_inst (
    .clk            (clk),
    .reset          (reset),
    .cachereq_val   (cachereq_val),
    .cachereq_rdy   (cachereq_rdy),
    .cachereq_msg   (cachereq_msg),
    .cacheresp_val  (cacheresp_val),
    .cacheresp_rdy  (cacheresp_rdy),
    .cacheresp_msg  (cacheresp_msg),
    .memreq_val     (memreq_val),
    .memreq_rdy     (memreq_rdy),
    .memreq_msg     (memreq_msg),
    .memresp_val    (memresp_val),
    .memresp_rdy    (memresp_rdy),
    .memresp_msg    (memresp_msg)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //==========================================================
  // Helpers
  //==========================================================
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    fill_word = addr ^ fill_key;
  endfunction

  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // Two bits at one step each give 0 to 3 cycles
  task automatic draw_delay(inout logic [31:0] s, output int d);
    d = 0;
    for (int i = 0; i < 2; i++) begin
      d = (d << 1) | s[0];
      s = lfsr_next(s);
    end
  endtask

  task automatic add_test(input string name, input cache_op_t op, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [31:0] exp_data,
                          input int rd, input int wr, input logic [31:0] wb,
                          input logic no_stall);
    test_t t;
    t.op       = op;
    t.addr     = addr;
    t.wdata    = wdata;
    t.exp_data = exp_data;
    t.exp_rd   = rd;
    t.exp_wr   = wr;
    t.exp_wb   = wb;
    t.no_stall = no_stall;
    tests.push_back(t);
    names.push_back(name);
  endtask

  //==========================================================
  // Memory model
  //==========================================================
  initial begin : mem_model
    mem_req_t req;
    int       d;
    memreq_rdy  = 1'b1;
    memresp_val = 1'b0;
    memresp_msg = '0;
    for (int a = 0; a < 4096; a += 4) begin
      ref_words[a / 4] = fill_word(a);
    end
    for (int i = 0; i < 256; i++) begin
      mem_lines[i] = {ref_words[4*i+3], ref_words[4*i+2], ref_words[4*i+1], ref_words[4*i]};
    end
    @(negedge clk);
    forever begin
      if (memreq_val === 1'b1) begin
        // Ready is always high so the transfer comes at the next rising edge
        req = memreq_msg;
        draw_delay(mem_lfsr, d);
        memresp_msg.op = req.op;
        if (req.op == cache_write) begin
          mem_writes++;
          last_wb_addr = req.addr;
          for (int w = 0; w < words_per_line; w++) begin
            if (req.data[w*32 +: 32] !== ref_words[req.addr[11:2] + w]) begin
              $display("mismatch %s writeback word %0d: expected %h, actual %h", cur_name, w,
                       ref_words[req.addr[11:2] + w], req.data[w*32 +: 32]);
              errors++;
            end
          end
          mem_lines[req.addr[11:4]] = req.data;
          memresp_msg.data = '0;
        end else begin
          mem_reads++;
          last_rd_addr = req.addr;
          memresp_msg.data = mem_lines[req.addr[11:4]];
        end
        @(negedge clk);
        repeat (d) @(negedge clk);
        memresp_val = 1'b1;
        while (memresp_rdy !== 1'b1) @(negedge clk);
        @(negedge clk);
        memresp_val = 1'b0;
      end else begin
        @(negedge clk);
      end
    end
  end

  //==========================================================
  // One table entry, request to response
  //==========================================================
  task automatic run_test(input int i);
    test_t       t;
    cache_resp_t resp;
    int          lat;
    int          d;
    int          rd0;
    int          wr0;
    int          err0;
    t        = tests[i];
    cur_name = names[i];
    rd0      = mem_reads;
    wr0      = mem_writes;
    err0     = errors;
    lat      = 0;
    d        = 0;
    if (!t.no_stall) draw_delay(resp_lfsr, d);
    cachereq_val      = 1'b1;
    cachereq_msg.op   = t.op;
    cachereq_msg.addr = t.addr;
    cachereq_msg.data = t.wdata;
    if (t.op == cache_write) ref_words[t.addr[11:2]] = t.wdata;
    while (cachereq_rdy !== 1'b1) @(negedge clk);
    @(negedge clk);
    cachereq_val = 1'b0;
    // Edges counted from the accepting edge to the response transfer
    while (cacheresp_val !== 1'b1) begin
      @(negedge clk);
      lat++;
    end
    repeat (d) begin
      @(negedge clk);
      lat++;
    end
    cacheresp_rdy = 1'b1;
    resp          = cacheresp_msg;
    @(negedge clk);
    lat++;
    cacheresp_rdy = 1'b0;
    if (resp.op !== t.op) begin
      $display("mismatch %s op: expected %0d, actual %0d", names[i], t.op, resp.op);
      errors++;
    end
    if (resp.data !== t.exp_data) begin
      $display("mismatch %s data: expected %h, actual %h", names[i], t.exp_data, resp.data);
      errors++;
    end
    if (t.op == cache_read && resp.data !== ref_words[t.addr[11:2]]) begin
      $display("mismatch %s reference: expected %h, actual %h", names[i],
               ref_words[t.addr[11:2]], resp.data);
      errors++;
    end
    if (mem_reads - rd0 != t.exp_rd) begin
      $display("mismatch %s reads: expected %0d, actual %0d", names[i],
               t.exp_rd, mem_reads - rd0);
      errors++;
    end
    if (t.exp_rd != 0 && last_rd_addr !== {t.addr[31:4], 4'h0}) begin
      $display("mismatch %s refill addr: expected %h, actual %h", names[i],
               {t.addr[31:4], 4'h0}, last_rd_addr);
      errors++;
    end
    if (mem_writes - wr0 != t.exp_wr) begin
      $display("mismatch %s writes: expected %0d, actual %0d", names[i],
               t.exp_wr, mem_writes - wr0);
      errors++;
    end
    if (t.exp_wr != 0 && last_wb_addr !== t.exp_wb) begin
      $display("mismatch %s wb addr: expected %h, actual %h", names[i], t.exp_wb, last_wb_addr);
      errors++;
    end
    if (t.no_stall && lat != 3) begin
      $display("mismatch %s latency: expected 3, actual %0d", names[i], lat);
      errors++;
    end
    $display("%s: %s", names[i], (errors == err0) ? "ok" : "failed");
  endtask

  //==========================================================
  // Stimulus
  //==========================================================
  initial begin : stimulus
    reset         = 1'b1;
    cachereq_val  = 1'b0;
    cachereq_msg  = '0;
    cacheresp_rdy = 1'b0;
    // Set 0 hit path, set 4 LRU, set 2 and set 0 write-back
    add_test("cold_read",     cache_read,  32'h104, 0, fill_word(32'h104), 1, 0, 0, 1'b0);
    add_test("hit_latency",   cache_read,  32'h10c, 0, fill_word(32'h10c), 0, 0, 0, 1'b1);
    add_test("write_hit",     cache_write, 32'h108, 32'h1234_5678, 0, 0, 0, 0, 1'b0);
    add_test("read_written",  cache_read,  32'h108, 0, 32'h1234_5678, 0, 0, 0, 1'b0);
    add_test("lru_fill_a",    cache_read,  32'h044, 0, fill_word(32'h044), 1, 0, 0, 1'b0);
    add_test("lru_fill_b",    cache_read,  32'h0c8, 0, fill_word(32'h0c8), 1, 0, 0, 1'b0);
    add_test("lru_touch_a",   cache_read,  32'h040, 0, fill_word(32'h040), 0, 0, 0, 1'b0);
    add_test("lru_fill_c",    cache_read,  32'h14c, 0, fill_word(32'h14c), 1, 0, 0, 1'b0);
    add_test("lru_keep_a",    cache_read,  32'h04c, 0, fill_word(32'h04c), 0, 0, 0, 1'b0);
    add_test("lru_refill_b",  cache_read,  32'h0c4, 0, fill_word(32'h0c4), 1, 0, 0, 1'b0);
    add_test("dirty_fill_d",  cache_write, 32'h024, 32'hdead_beef, 0, 1, 0, 0, 1'b0);
    add_test("dirty_word_d",  cache_write, 32'h02c, 32'hcafe_f00d, 0, 0, 0, 0, 1'b0);
    add_test("fill_e",        cache_read,  32'h0a0, 0, fill_word(32'h0a0), 1, 0, 0, 1'b0);
    add_test("evict_d",       cache_read,  32'h128, 0, fill_word(32'h128), 1, 1, 32'h020, 1'b0);
    add_test("reload_d",      cache_read,  32'h024, 0, 32'hdead_beef, 1, 0, 0, 1'b0);
    add_test("reload_d_word", cache_read,  32'h02c, 0, 32'hcafe_f00d, 0, 0, 0, 1'b0);
    add_test("fill_set0",     cache_read,  32'h184, 0, fill_word(32'h184), 1, 0, 0, 1'b0);
    add_test("evict_100",     cache_read,  32'h208, 0, fill_word(32'h208), 1, 1, 32'h100, 1'b0);
    add_test("reload_100",    cache_read,  32'h108, 0, 32'h1234_5678, 1, 0, 0, 1'b0);
    add_test("reload_100_hit", cache_read, 32'h104, 0, fill_word(32'h104), 0, 0, 0, 1'b0);
    repeat (reset_cycles) @(negedge clk);
    if (cachereq_rdy !== 1'b1 || cacheresp_val !== 1'b0 || memreq_val !== 1'b0) begin
      $display("cache not idle after reset: cachereq_rdy %b, cacheresp_val %b, memreq_val %b",
               cachereq_rdy, cacheresp_val, memreq_val);
      errors++;
    end
    reset = 1'b0;
    for (int i = 0; i < tests.size(); i++) begin
      run_test(i);
    end
    $display("%0d tests run, %0d errors", tests.size(), errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Run limit from the table length
  initial begin : watchdog
    int cycles;
    int limit;
    @(posedge clk);
    limit  = tests.size() * 64 + reset_cycles;
    cycles = 1;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("run stopped: the tests did not finish within %0d cycles", limit);
    $display("Finished with errors");
    $finish;
  end

endmodule

/* sources.f */
cache_pkg.sv
cache_tag_array.sv
cache_data_array.sv
cache_datapath.sv
cache_ctrl.sv
blocking_cache.sv
cache_props.sv
cache_tb.sv
